//--- common/map_params.svh
`ifndef MAP_PARAMS_SVH
`define MAP_PARAMS_SVH

// brick population, one mask bit per brick
`define BRICK_COUNT 100

// screen coordinate width, enough for 640x480
`define COORD_W 10

// brick is 16x16, span is size minus one
`define BRICK_SPAN 15

// edge distance at which a tank is held back
`define STOP_GAP 2
// side overlap allowed along the blocked edge
`define STOP_REACH 32

// enemy bullet is 4x4 from its top-left corner
`define ENEMY_BULLET_SPAN 3

// wall interior, all bounds exclusive
`define WALL_LO_X 31
`define WALL_HI_X 608
`define WALL_LO_Y 31
`define WALL_HI_Y 448

// bricks 0 to 19 guard the eagle
`define EAGLE_COUNT 20

// origin and group pitch of the field layouts
`define FIELD_X0 96
`define FIELD_Y0 80
`define FIELD_STEP 64

`endif

//--- common/map_pkg.sv
`default_nettype none
`include "map_params.svh"

package map_pkg;

    // one screen coordinate, x or y
    typedef logic [`COORD_W-1:0] coord_t;

    // one bit per brick, bit i is brick i
    typedef logic [`BRICK_COUNT-1:0] brick_mask_t;

    // bounding box of a tank or bullet
    // left/right along x, top/bottom along y
    typedef struct packed {
        coord_t left;
        coord_t right;
        coord_t top;
        coord_t bottom;
    } box_t;

endpackage : map_pkg

`default_nettype wire

//--- brick_field/brick_store.sv
`default_nettype none
`include "map_params.svh"

module brick_store import map_pkg::*; (
    input  logic        clk_50MHz,
    input  logic        reset,
    input  logic        map_index,
    input  brick_mask_t destroy,
    output coord_t      brick_x [`BRICK_COUNT],
    output coord_t      brick_y [`BRICK_COUNT],
    output brick_mask_t alive
);

    // field bricks come in lines of 20
    localparam int GROUP_LEN = 20;
    localparam int GROUPS    = (`BRICK_COUNT - `EAGLE_COUNT) / GROUP_LEN;
    // neighbour pitch inside a line, bricks touch
    localparam int TILE      = `BRICK_SPAN + 1;

    // eagle cover, listed column by column
    //    **
    //   ****
    //  ******
    //  **  **
    //  **  **
    localparam coord_t EAGLE_X [`EAGLE_COUNT] = '{
        10'd288, 10'd288, 10'd288,
        10'd304, 10'd304, 10'd304, 10'd304,
        10'd320, 10'd320, 10'd320,
        10'd336, 10'd336, 10'd336,
        10'd352, 10'd352, 10'd352, 10'd352,
        10'd368, 10'd368, 10'd368
    };
    localparam coord_t EAGLE_Y [`EAGLE_COUNT] = '{
        10'd432, 10'd416, 10'd400,
        10'd432, 10'd416, 10'd400, 10'd384,
        10'd400, 10'd384, 10'd368,
        10'd400, 10'd384, 10'd368,
        10'd432, 10'd416, 10'd400, 10'd384,
        10'd432, 10'd416, 10'd400
    };

    // layout loads while reset held, positions then stay put
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < `EAGLE_COUNT; e++) begin
                brick_x[e] <= EAGLE_X[e];
                brick_y[e] <= EAGLE_Y[e];
            end
            for (int g = 0; g < GROUPS; g++) begin
                for (int k = 0; k < GROUP_LEN; k++) begin
                    if (map_index == 1'b0) begin
                        // map 0, vertical columns
                        brick_x[`EAGLE_COUNT + g*GROUP_LEN + k] <=
                            coord_t'(`FIELD_X0 + `FIELD_STEP*g);
                        brick_y[`EAGLE_COUNT + g*GROUP_LEN + k] <=
                            coord_t'(`FIELD_Y0 + TILE*k);
                    end else begin
                        // map 1, horizontal rows
                        brick_x[`EAGLE_COUNT + g*GROUP_LEN + k] <=
                            coord_t'(`FIELD_X0 + TILE*k);
                        brick_y[`EAGLE_COUNT + g*GROUP_LEN + k] <=
                            coord_t'(`FIELD_Y0 + `FIELD_STEP*g);
                    end
                end
            end
            alive <= '1;
        end else begin
            // dead bricks stay dead until next reset
            alive <= alive & ~destroy;
        end
    end

    // once out of reset no brick comes back to life
    a_alive_no_rise : assert property (
        @(posedge clk_50MHz) disable iff (!reset)
        (alive & ~$past(alive)) == '0
    ) else $error("brick_store: alive bit rose outside reset");

endmodule : brick_store

`default_nettype wire

//--- brick_field/bullet_collide.sv
`default_nettype none
`include "map_params.svh"

module bullet_collide import map_pkg::*; (
    input  logic        clk_50MHz,
    input  logic        reset,
    input  logic        refresh_tick,
    input  coord_t      brick_x [`BRICK_COUNT],
    input  coord_t      brick_y [`BRICK_COUNT],
    input  brick_mask_t alive,
    input  coord_t      bullet_l,
    input  coord_t      bullet_r,
    input  coord_t      bullet_t,
    input  coord_t      bullet_b,
    input  coord_t      enemy_bullet_x,
    input  coord_t      enemy_bullet_y,
    output brick_mask_t destroy,
    output logic        hit,
    output logic        hit_by_enemy
);

    // one extra bit so brick and bullet far edges never wrap
    typedef logic [`COORD_W:0] wide_t;

    brick_mask_t player_strike;
    brick_mask_t enemy_strike;

    // strict overlap of a box with the brick at (bx, by)
    function automatic logic strike(wide_t l, wide_t r, wide_t t, wide_t b,
                                    coord_t bx, coord_t by);
        wide_t far_x;
        wide_t far_y;
        far_x = {1'b0, bx} + wide_t'(`BRICK_SPAN);
        far_y = {1'b0, by} + wide_t'(`BRICK_SPAN);
        return (t < far_y) && (b > {1'b0, by}) && (l < far_x) && (r > {1'b0, bx});
    endfunction

    // only live bricks, only on a refresh tick
    always_comb begin
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            player_strike[i] = refresh_tick && alive[i] &&
                strike({1'b0, bullet_l}, {1'b0, bullet_r},
                       {1'b0, bullet_t}, {1'b0, bullet_b},
                       brick_x[i], brick_y[i]);
            // enemy bullet far edges from its corner
            enemy_strike[i] = refresh_tick && alive[i] &&
                strike({1'b0, enemy_bullet_x},
                       {1'b0, enemy_bullet_x} + wide_t'(`ENEMY_BULLET_SPAN),
                       {1'b0, enemy_bullet_y},
                       {1'b0, enemy_bullet_y} + wide_t'(`ENEMY_BULLET_SPAN),
                       brick_x[i], brick_y[i]);
        end
    end

    assign destroy = player_strike | enemy_strike;

    // single-cycle pulses, the tick is one cycle wide
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            hit          <= 1'b0;
            hit_by_enemy <= 1'b0;
        end else begin
            hit          <= |player_strike;
            hit_by_enemy <= |enemy_strike;
        end
    end

    a_hit_after_tick : assert property (
        @(posedge clk_50MHz) disable iff (!reset)
        (hit || hit_by_enemy) |-> $past(refresh_tick)
    ) else $error("bullet_collide: hit pulse without preceding tick");

endmodule : bullet_collide

`default_nettype wire

//--- rtl/block_stop.sv
`default_nettype none
`include "map_params.svh"

module block_stop import map_pkg::*; (
    input  coord_t      brick_x [`BRICK_COUNT],
    input  coord_t      brick_y [`BRICK_COUNT],
    input  brick_mask_t alive,
    input  coord_t      mover_l,
    input  coord_t      mover_r,
    input  coord_t      mover_t,
    input  coord_t      mover_b,
    output brick_mask_t stop_up,
    output brick_mask_t stop_down,
    output brick_mask_t stop_left,
    output brick_mask_t stop_right
);

    // widened so +gap and +reach stay exact
    typedef logic [`COORD_W:0] wide_t;

    // mover spans near..far along the side, brick spans lo..hi
    // near edge checked as near+reach >= lo to avoid underflow
    function automatic logic side_ok(coord_t near, coord_t far, wide_t lo, wide_t hi);
        return ({1'b0, far} <= hi + wide_t'(`STOP_REACH)) &&
               ({1'b0, near} + wide_t'(`STOP_REACH) >= lo);
    endfunction

    always_comb begin
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            // brick edges
            wide_t b_l;
            wide_t b_r;
            wide_t b_t;
            wide_t b_b;
            b_l = {1'b0, brick_x[i]};
            b_r = {1'b0, brick_x[i]} + wide_t'(`BRICK_SPAN);
            b_t = {1'b0, brick_y[i]};
            b_b = {1'b0, brick_y[i]} + wide_t'(`BRICK_SPAN);

            // moving up, brick sits above
            stop_up[i] = alive[i] && ({1'b0, mover_t} == b_b + wide_t'(`STOP_GAP)) &&
                side_ok(mover_l, mover_r, b_l, b_r);
            // moving down, brick below, gap added on mover side
            stop_down[i] = alive[i] && ({1'b0, mover_b} + wide_t'(`STOP_GAP) == b_t) &&
                side_ok(mover_l, mover_r, b_l, b_r);
            // moving left, brick to the left
            stop_left[i] = alive[i] && ({1'b0, mover_l} == b_r + wide_t'(`STOP_GAP)) &&
                side_ok(mover_t, mover_b, b_t, b_b);
            // moving right
            stop_right[i] = alive[i] && ({1'b0, mover_r} + wide_t'(`STOP_GAP) == b_l) &&
                side_ok(mover_t, mover_b, b_t, b_b);
        end
    end

    // a well-formed mover box can't touch both brick faces at once
    always_comb begin
        a_up_down_excl : assert #0 ((stop_up & stop_down) == '0)
            else $error("block_stop: up and down stop on same brick");
    end

endmodule : block_stop

`default_nettype wire

//--- rtl/pixel_overlay.sv
`default_nettype none
`include "map_params.svh"

module pixel_overlay import map_pkg::*; (
    input  coord_t      x,
    input  coord_t      y,
    input  coord_t      brick_x [`BRICK_COUNT],
    input  coord_t      brick_y [`BRICK_COUNT],
    input  brick_mask_t alive,
    output brick_mask_t brick_on,
    output logic        wall_on
);

    // far edges need the carry bit
    typedef logic [`COORD_W:0] wide_t;

    // pixel inside a live brick, edges included
    always_comb begin
        for (int i = 0; i < `BRICK_COUNT; i++) begin
            brick_on[i] = alive[i] &&
                (x >= brick_x[i]) &&
                ({1'b0, x} <= {1'b0, brick_x[i]} + wide_t'(`BRICK_SPAN)) &&
                (y >= brick_y[i]) &&
                ({1'b0, y} <= {1'b0, brick_y[i]} + wide_t'(`BRICK_SPAN));
        end
    end

    // border wall is anything outside the open interior
    assign wall_on = !((x > coord_t'(`WALL_LO_X)) && (x < coord_t'(`WALL_HI_X)) &&
                       (y > coord_t'(`WALL_LO_Y)) && (y < coord_t'(`WALL_HI_Y)));

endmodule : pixel_overlay

`default_nettype wire

//--- rtl/map_top.sv
`default_nettype none
`include "map_params.svh"

module map_top import map_pkg::*; (
    input  logic        clk_50MHz,
    input  logic        reset,
    input  logic        refresh_tick,
    input  logic        map_index,
    // vga pixel
    input  coord_t      x,
    input  coord_t      y,
    // player tank box
    input  coord_t      x_tank_l,
    input  coord_t      x_tank_r,
    input  coord_t      y_tank_t,
    input  coord_t      y_tank_b,
    // enemy tank box
    input  coord_t      x_enemy_l,
    input  coord_t      x_enemy_r,
    input  coord_t      y_enemy_t,
    input  coord_t      y_enemy_b,
    // player bullet box
    input  coord_t      x_bullet_l,
    input  coord_t      x_bullet_r,
    input  coord_t      y_bullet_t,
    input  coord_t      y_bullet_b,
    // enemy bullet corner
    input  coord_t      x_bullet_enemy,
    input  coord_t      y_bullet_enemy,
    output logic        hit,
    output logic        hit_by_enemy,
    output brick_mask_t stop_go_up,
    output brick_mask_t stop_go_down,
    output brick_mask_t stop_go_left,
    output brick_mask_t stop_go_right,
    output brick_mask_t stop_enemy_go_up,
    output brick_mask_t stop_enemy_go_down,
    output brick_mask_t stop_enemy_go_left,
    output brick_mask_t stop_enemy_go_right,
    output brick_mask_t brick_on,
    output logic        wall_on
);

    // brick state shared by all units
    coord_t      brick_x [`BRICK_COUNT];
    coord_t      brick_y [`BRICK_COUNT];
    brick_mask_t alive;
    brick_mask_t destroy;

    brick_store store (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .map_index (map_index),
        .destroy   (destroy),
        .brick_x   (brick_x),
        .brick_y   (brick_y),
        .alive     (alive)
    );

    bullet_collide collide (
        .clk_50MHz      (clk_50MHz),
        .reset          (reset),
        .refresh_tick   (refresh_tick),
        .brick_x        (brick_x),
        .brick_y        (brick_y),
        .alive          (alive),
        .bullet_l       (x_bullet_l),
        .bullet_r       (x_bullet_r),
        .bullet_t       (y_bullet_t),
        .bullet_b       (y_bullet_b),
        .enemy_bullet_x (x_bullet_enemy),
        .enemy_bullet_y (y_bullet_enemy),
        .destroy        (destroy),
        .hit            (hit),
        .hit_by_enemy   (hit_by_enemy)
    );

    // player tank
    block_stop tank_stop (
        .brick_x    (brick_x),
        .brick_y    (brick_y),
        .alive      (alive),
        .mover_l    (x_tank_l),
        .mover_r    (x_tank_r),
        .mover_t    (y_tank_t),
        .mover_b    (y_tank_b),
        .stop_up    (stop_go_up),
        .stop_down  (stop_go_down),
        .stop_left  (stop_go_left),
        .stop_right (stop_go_right)
    );

    // enemy tank
    block_stop enemy_stop (
        .brick_x    (brick_x),
        .brick_y    (brick_y),
        .alive      (alive),
        .mover_l    (x_enemy_l),
        .mover_r    (x_enemy_r),
        .mover_t    (y_enemy_t),
        .mover_b    (y_enemy_b),
        .stop_up    (stop_enemy_go_up),
        .stop_down  (stop_enemy_go_down),
        .stop_left  (stop_enemy_go_left),
        .stop_right (stop_enemy_go_right)
    );

    pixel_overlay overlay (
        .x        (x),
        .y        (y),
        .brick_x  (brick_x),
        .brick_y  (brick_y),
        .alive    (alive),
        .brick_on (brick_on),
        .wall_on  (wall_on)
    );

endmodule : map_top

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none

module clock_gen (
    input  logic reset_req,
    output logic clk_50MHz,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  RESET_CYCLES = 16;
    localparam real HALF_PERIOD  = 10.0;

    // rising edges seen since the last reset request
    int   count = 0;
    logic reset_q = 1'b0;

    // 50 MHz, 20 ns period
    initial begin
        clk_50MHz = 1'b0;
        forever #(HALF_PERIOD) clk_50MHz = ~clk_50MHz;
    end

    // a request restarts the count
    always @(posedge clk_50MHz) begin
        if (reset_req) begin
            count <= 0;
        end else if (count < RESET_CYCLES) begin
            count <= count + 1;
        end
    end

    // reset changes on falling edges, clear of the DUT's clock edge
    always @(negedge clk_50MHz) begin
        reset_q <= (count >= RESET_CYCLES);
    end

    assign reset = reset_q;

endmodule : clock_gen

`default_nettype wire

//--- tests/tb_map.sv
`default_nettype none
`include "map_params.svh"

module tb_map import map_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // tanks are 32x32, bullets in the records are 4x4
    localparam int MOVER_SPAN      = 31;
    localparam int PBULLET_SPAN    = 3;
    localparam int LINE_LEN        = 20;
    localparam int TILE            = 16;
    localparam int CYCLES_PER_TEST = 40;

    // eagle cover, column by column
    localparam int EAGLE_X [20] = '{288, 288, 288, 304, 304, 304, 304, 320, 320, 320,
                                    336, 336, 336, 352, 352, 352, 352, 368, 368, 368};
    localparam int EAGLE_Y [20] = '{432, 416, 400, 432, 416, 400, 384, 400, 384, 368,
                                    400, 384, 368, 432, 416, 400, 384, 432, 416, 400};

    // one line of the pattern file
    typedef struct {
        string kind;
        string name;
        int    map;
        int    brick;
        int    a;
        int    b;
        int    c;
        int    tick;
        int    exp;
    } record_t;

    logic        clk_50MHz;
    logic        reset;
    logic        reset_req;
    logic        refresh_tick;
    logic        map_index;
    coord_t      x;
    coord_t      y;
    coord_t      x_tank_l;
    coord_t      x_tank_r;
    coord_t      y_tank_t;
    coord_t      y_tank_b;
    coord_t      x_enemy_l;
    coord_t      x_enemy_r;
    coord_t      y_enemy_t;
    coord_t      y_enemy_b;
    coord_t      x_bullet_l;
    coord_t      x_bullet_r;
    coord_t      y_bullet_t;
    coord_t      y_bullet_b;
    coord_t      x_bullet_enemy;
    coord_t      y_bullet_enemy;
    logic        hit;
    logic        hit_by_enemy;
    brick_mask_t stop_go_up;
    brick_mask_t stop_go_down;
    brick_mask_t stop_go_left;
    brick_mask_t stop_go_right;
    brick_mask_t stop_enemy_go_up;
    brick_mask_t stop_enemy_go_down;
    brick_mask_t stop_enemy_go_left;
    brick_mask_t stop_enemy_go_right;
    brick_mask_t brick_on;
    logic        wall_on;

    record_t recs[$];
    int      cur_map      = -1;
    int      errors       = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      cycles       = 0;
    int      cycle_limit  = 0;
    logic    load_ok      = 1'b1;

    clock_gen clocks (
        .reset_req (reset_req),
        .clk_50MHz (clk_50MHz),
        .reset     (reset)
    );

    map_top uut (
        .clk_50MHz           (clk_50MHz),
        .reset               (reset),
        .refresh_tick        (refresh_tick),
        .map_index           (map_index),
        .x                   (x),
        .y                   (y),
        .x_tank_l            (x_tank_l),
        .x_tank_r            (x_tank_r),
        .y_tank_t            (y_tank_t),
        .y_tank_b            (y_tank_b),
        .x_enemy_l           (x_enemy_l),
        .x_enemy_r           (x_enemy_r),
        .y_enemy_t           (y_enemy_t),
        .y_enemy_b           (y_enemy_b),
        .x_bullet_l          (x_bullet_l),
        .x_bullet_r          (x_bullet_r),
        .y_bullet_t          (y_bullet_t),
        .y_bullet_b          (y_bullet_b),
        .x_bullet_enemy      (x_bullet_enemy),
        .y_bullet_enemy      (y_bullet_enemy),
        .hit                 (hit),
        .hit_by_enemy        (hit_by_enemy),
        .stop_go_up          (stop_go_up),
        .stop_go_down        (stop_go_down),
        .stop_go_left        (stop_go_left),
        .stop_go_right       (stop_go_right),
        .stop_enemy_go_up    (stop_enemy_go_up),
        .stop_enemy_go_down  (stop_enemy_go_down),
        .stop_enemy_go_left  (stop_enemy_go_left),
        .stop_enemy_go_right (stop_enemy_go_right),
        .brick_on            (brick_on),
        .wall_on             (wall_on)
    );

    // brick origin from the layout rule
    function automatic void brick_origin(input int idx, input int m,
                                         output int bx, output int by);
        int g;
        int k;
        g = (idx - `EAGLE_COUNT) / LINE_LEN;
        k = (idx - `EAGLE_COUNT) % LINE_LEN;
        if (idx < `EAGLE_COUNT) begin
            bx = EAGLE_X[idx];
            by = EAGLE_Y[idx];
        end else if (m == 0) begin
            // map 0, columns
            bx = `FIELD_X0 + `FIELD_STEP * g;
            by = `FIELD_Y0 + TILE * k;
        end else begin
            // map 1, rows
            bx = `FIELD_X0 + TILE * k;
            by = `FIELD_Y0 + `FIELD_STEP * g;
        end
    endfunction

    // -1 means no bit at all
    function automatic brick_mask_t expect_mask(input int idx);
        brick_mask_t m;
        m = '0;
        if (idx >= 0) begin
            m[idx] = 1'b1;
        end
        return m;
    endfunction

    task automatic check_mask(input brick_mask_t got, input brick_mask_t want,
                              input string what);
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // every box parked at the origin, no tick
    task automatic set_idle();
        refresh_tick   = 1'b0;
        x              = '0;
        y              = '0;
        x_tank_l       = '0;
        x_tank_r       = '0;
        y_tank_t       = '0;
        y_tank_b       = '0;
        x_enemy_l      = '0;
        x_enemy_r      = '0;
        y_enemy_t      = '0;
        y_enemy_b      = '0;
        x_bullet_l     = '0;
        x_bullet_r     = '0;
        y_bullet_t     = '0;
        y_bullet_b     = '0;
        x_bullet_enemy = '0;
        y_bullet_enemy = '0;
    endtask

    // new layout needs a fresh reset
    task automatic restart_map(input int m);
        map_index = m[0];
        reset_req = 1'b1;
        @(negedge clk_50MHz);
        reset_req = 1'b0;
        wait (reset == 1'b0);
        wait (reset == 1'b1);
        @(negedge clk_50MHz);
        cur_map = m;
    endtask

    task automatic read_patterns();
        int      fd;
        int      n;
        string   kind;
        string   rest;
        record_t r;
        fd = $fopen("tests/map_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/map_patterns.txt for reading");
            load_ok = 1'b0;
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind.getc(0) == "#") begin
                // comment, drop the rest of the line
                n = $fgets(rest, fd);
            end else begin
                r.kind = kind;
                n = $fscanf(fd, "%s %d %d %d %d %d %d %d", r.name, r.map, r.brick,
                            r.a, r.b, r.c, r.tick, r.exp);
                if (n != 8) begin
                    $display("Malformed pattern record after kind %s", kind);
                    load_ok = 1'b0;
                end else begin
                    recs.push_back(r);
                end
            end
        end
        $fclose(fd);
    endtask

    // pixel probe, relative to a brick or absolute
    task automatic run_pixel(input record_t r);
        int bx;
        int by;
        bx = 0;
        by = 0;
        if (r.brick >= 0) begin
            brick_origin(r.brick, r.map, bx, by);
        end
        x = coord_t'(bx + r.a);
        y = coord_t'(by + r.b);
        @(negedge clk_50MHz);
        if (r.kind == "wall") begin
            check_flag(wall_on, r.exp[0], {r.name, " wall_on"});
        end else begin
            check_mask(brick_on, expect_mask(r.exp), {r.name, " brick_on"});
            // all bricks lie inside the wall
            check_flag(wall_on, 1'b0, {r.name, " wall_on"});
        end
    endtask

    // mover placed against one face of a brick
    task automatic run_stop(input record_t r, input logic enemy);
        int          bx;
        int          by;
        int          l;
        int          t;
        box_t        mv;
        brick_mask_t got;
        brick_origin(r.brick, r.map, bx, by);
        case (r.a)
            0: begin
                l = bx + r.c;
                t = by + `BRICK_SPAN + r.b;
            end
            1: begin
                l = bx + r.c;
                t = by - r.b - MOVER_SPAN;
            end
            2: begin
                l = bx + `BRICK_SPAN + r.b;
                t = by + r.c;
            end
            default: begin
                l = bx - r.b - MOVER_SPAN;
                t = by + r.c;
            end
        endcase
        mv.left   = coord_t'(l);
        mv.right  = coord_t'(l + MOVER_SPAN);
        mv.top    = coord_t'(t);
        mv.bottom = coord_t'(t + MOVER_SPAN);
        if (enemy) begin
            x_enemy_l = mv.left;
            x_enemy_r = mv.right;
            y_enemy_t = mv.top;
            y_enemy_b = mv.bottom;
        end else begin
            x_tank_l = mv.left;
            x_tank_r = mv.right;
            y_tank_t = mv.top;
            y_tank_b = mv.bottom;
        end
        @(negedge clk_50MHz);
        case (r.a)
            0:       got = enemy ? stop_enemy_go_up : stop_go_up;
            1:       got = enemy ? stop_enemy_go_down : stop_go_down;
            2:       got = enemy ? stop_enemy_go_left : stop_go_left;
            default: got = enemy ? stop_enemy_go_right : stop_go_right;
        endcase
        check_mask(got, expect_mask(r.exp), {r.kind, " ", r.name, " stop mask"});
    endtask

    // bullet over a brick, pulse, then look at the brick
    task automatic run_bullet(input record_t r);
        int   bx;
        int   by;
        box_t shot;
        logic enemy;
        enemy = (r.kind == "ebul");
        brick_origin(r.brick, r.map, bx, by);
        if (enemy) begin
            x_bullet_enemy = coord_t'(bx + r.a);
            y_bullet_enemy = coord_t'(by + r.b);
        end else begin
            shot.left   = coord_t'(bx + r.a);
            shot.right  = coord_t'(bx + r.a + PBULLET_SPAN);
            shot.top    = coord_t'(by + r.b);
            shot.bottom = coord_t'(by + r.b + PBULLET_SPAN);
            x_bullet_l  = shot.left;
            x_bullet_r  = shot.right;
            y_bullet_t  = shot.top;
            y_bullet_b  = shot.bottom;
        end
        refresh_tick = r.tick[0];
        @(negedge clk_50MHz);
        // pulse one cycle after the tick edge
        check_flag(hit, !enemy && (r.exp != 0), {r.name, " hit"});
        check_flag(hit_by_enemy, enemy && (r.exp != 0), {r.name, " hit_by_enemy"});
        refresh_tick = 1'b0;
        @(negedge clk_50MHz);
        check_flag(hit, 1'b0, {r.name, " hit after pulse"});
        check_flag(hit_by_enemy, 1'b0, {r.name, " hit_by_enemy after pulse"});
        // brick still drawn only if it survived
        set_idle();
        x = coord_t'(bx);
        y = coord_t'(by);
        @(negedge clk_50MHz);
        check_mask(brick_on, expect_mask((r.c != 0) ? r.brick : -1),
                   {r.name, " brick_on after"});
    endtask

    task automatic run_record(input record_t r);
        int errors_before;
        errors_before = errors;
        if (r.map != cur_map) begin
            restart_map(r.map);
        end
        set_idle();
        case (r.kind)
            "pix", "wall": run_pixel(r);
            "tank":        run_stop(r, 1'b0);
            "enemy":       run_stop(r, 1'b1);
            "pbul", "ebul": run_bullet(r);
            default: begin
                errors++;
                $display("Unknown test kind %s in record %s", r.kind, r.name);
            end
        endcase
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s (%s) passed", r.name, r.kind);
        end else begin
            tests_failed++;
            $display("test %s (%s) had %0d errors", r.name, r.kind, errors - errors_before);
        end
    endtask

    // run length bound from the record count
    always @(posedge clk_50MHz) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        reset_req = 1'b0;
        map_index = 1'b0;
        set_idle();
        read_patterns();
        cycle_limit = recs.size() * CYCLES_PER_TEST + 200;
        if (load_ok) begin
            foreach (recs[i]) begin
                run_record(recs[i]);
            end
        end
        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (load_ok && errors == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_map

`default_nettype wire

//--- tests/map_patterns.txt
# kind name map brick a b c tick exp; pix/wall pixel = brick origin + (a,b), absolute for -1
# tank/enemy a 0 up 1 down 2 left 3 right, b gap, c side shift; bullets c is alive after
pix eagle0_org 0 0 0 0 0 0 0
pix eagle0_far 0 0 15 15 0 0 0
pix eagle9_org 0 9 0 0 0 0 9
pix col1_org 0 45 0 0 0 0 45
pix col1_far 0 45 15 15 0 0 45
pix col3_top 0 80 0 0 0 0 80
pix gap_cols 0 -1 120 100 0 0 -1
wall wall_left 0 -1 31 200 0 0 1
wall wall_right 0 -1 608 200 0 0 1
wall wall_top 0 -1 200 31 0 0 1
wall wall_bottom 0 -1 200 448 0 0 1
wall inner_tl 0 -1 32 32 0 0 0
wall inner_br 0 -1 607 447 0 0 0
tank up_gap2 0 45 0 2 0 0 45
tank up_gap1 0 45 0 1 0 0 -1
tank up_gap3 0 45 0 3 0 0 -1
tank up_reach_lo 0 45 0 2 -32 0 45
tank up_reach_out 0 45 0 2 -33 0 -1
tank down_gap2 0 45 1 2 0 0 45
tank down_reach_hi 0 45 1 2 16 0 45
tank down_reach_out 0 45 1 2 17 0 -1
enemy up_gap2 0 46 0 2 0 0 46
enemy down_gap2 0 46 1 2 0 0 46
enemy down_gap3 0 46 1 3 0 0 -1
pbul no_tick 0 33 4 4 1 0 0
pbul tick_hit 0 33 4 4 0 1 1
tank dead_up 0 33 0 2 0 0 -1
ebul edge_left 0 30 -3 4 1 1 0
ebul edge_right 0 30 15 4 1 1 0
ebul corner_hit 0 30 -2 4 0 1 1
enemy dead_down 0 30 1 2 0 0 -1
pix row2_org 1 67 0 0 0 0 67
pix row2_far 1 67 15 15 0 0 67
pix eagle5_org 1 5 0 0 0 0 5
pix gap_rows 1 -1 100 120 0 0 -1
tank left_gap2 1 67 2 2 0 0 67
tank left_gap1 1 67 2 1 0 0 -1
tank left_gap3 1 67 2 3 0 0 -1
tank left_reach_hi 1 67 2 2 16 0 67
tank left_reach_out 1 67 2 2 17 0 -1
tank right_gap2 1 67 3 2 0 0 67
enemy left_gap2 1 67 2 2 0 0 67
enemy right_gap2 1 67 3 2 0 0 67
enemy right_reach_lo 1 67 3 2 -32 0 67
enemy right_reach_out 1 67 3 2 -33 0 -1
pbul row_hit 1 67 4 4 0 1 1
pix revived 0 33 0 0 0 0 33

//--- vlog.f
+incdir+common
common/map_pkg.sv
brick_field/brick_store.sv
brick_field/bullet_collide.sv
rtl/block_stop.sv
rtl/pixel_overlay.sv
rtl/map_top.sv
tests/clock_gen.sv
tests/tb_map.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_map
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
